//--- logic/synth_types_pkg.sv
package synth_types_pkg;

    // --------------------
    // Register payload and addressing

    typedef logic signed [7:0] ctrl_byte_t;     // Every stored parameter and the bus data

    typedef logic [6:0] ctrl_adr_t;             // Oscillator index in [6:4], field in [3:0]

    typedef logic [3:0] midi_ch_t;              // Channel 0 to 15

    // --------------------
    // Read steering

    // Region that a read is served from
    typedef enum logic [2:0] {
        REGION_NONE,                            // No read this cycle
        REGION_OSC,
        REGION_COM,
        REGION_MAT1,
        REGION_MAT2
    } reg_region_t;

endpackage

//--- logic/synth_map_pkg.sv
package synth_map_pkg;

    // --------------------
    // Voice geometry

    localparam int V_OSC         = 4;           // Oscillators per voice
    localparam int MAT_SLOTS     = 16;          // Matrix entries per oscillator column
    localparam int NAME_LEN      = 16;          // Patch name characters

    localparam int OSC_IDX_W     = 3;           // Width of adr[6:4]
    localparam int SUB_ADR_W     = 4;           // Width of adr[3:0]
    localparam int NAME_IDX_W    = $clog2(NAME_LEN);

    // --------------------
    // Oscillator window, 16 addresses per oscillator

    localparam logic [SUB_ADR_W-1:0] FIELD_LVL       = 4'd2;
    localparam logic [SUB_ADR_W-1:0] FIELD_MOD_OUT   = 4'd3;
    localparam logic [SUB_ADR_W-1:0] FIELD_FEEDB_OUT = 4'd4;
    localparam logic [SUB_ADR_W-1:0] FIELD_PAN       = 4'd7;
    localparam logic [SUB_ADR_W-1:0] FIELD_MOD_IN    = 4'd10;
    localparam logic [SUB_ADR_W-1:0] FIELD_FEEDB_IN  = 4'd11;

    // Common region
    localparam int COM_VOL       = 1;
    localparam int COM_CH        = 2;
    localparam int COM_NAME_BASE = 16;          // Name occupies 16 to 31

    // --------------------
    // Reset values

    localparam logic [7:0] LVL_ON       = 8'h40;
    localparam int         LVL_ON_COUNT = 2;    // Oscillators that start audible
    localparam logic [7:0] PAN_CENTER   = 8'h40;
    localparam logic [7:0] VOL_DEFAULT  = 8'h40;
    localparam logic [7:0] NAME_FILL    = 8'd32;    // ASCII space

endpackage

//--- logic/ctrl_bus_decoder.sv
`timescale 1ns/10ps

module ctrl_bus_decoder
    import synth_types_pkg::*;
    import synth_map_pkg::*;
(
    input  ctrl_adr_t               adr,
    input  logic                    write,
    input  logic                    read,
    input  logic                    osc_sel,
    input  logic                    com_sel,
    input  logic                    m1_sel,
    input  logic                    m2_sel,
    output logic [V_OSC-1:0]        osc_wr,
    output logic [V_OSC-1:0]        mat1_wr,
    output logic [V_OSC-1:0]        mat2_wr,
    output logic                    com_wr,
    output logic [SUB_ADR_W-1:0]    sub_adr,
    output reg_region_t             rd_region,
    output logic [OSC_IDX_W-1:0]    rd_osc
);

    logic [OSC_IDX_W-1:0]   osc_idx;
    logic                   osc_ok;
    logic [V_OSC-1:0]       osc_onehot;
    reg_region_t            sel_region;
    logic                   hit;

    assign osc_idx = adr[SUB_ADR_W +: OSC_IDX_W];
    assign sub_adr = adr[SUB_ADR_W-1:0];
    assign osc_ok  = (osc_idx < V_OSC);
    assign osc_onehot = osc_ok ? ({{(V_OSC-1){1'b0}}, 1'b1} << osc_idx) : '0;

    // --------------------
    // Select priority, resolved once
    always_comb begin
        if (osc_sel)
            sel_region = REGION_OSC;
        else if (com_sel)
            sel_region = REGION_COM;
        else if (m1_sel)
            sel_region = REGION_MAT1;
        else if (m2_sel)
            sel_region = REGION_MAT2;
        else
            sel_region = REGION_NONE;
    end

    // Common region ignores the oscillator index
    assign hit = (sel_region == REGION_COM) ||
                 ((sel_region != REGION_NONE) && osc_ok);

    always_comb begin
        osc_wr  = '0;
        mat1_wr = '0;
        mat2_wr = '0;
        com_wr  = 1'b0;
        if (write && hit) begin
            case (sel_region)
                REGION_OSC:  osc_wr  = osc_onehot;
                REGION_MAT1: mat1_wr = osc_onehot;
                REGION_MAT2: mat2_wr = osc_onehot;
                REGION_COM:  com_wr  = 1'b1;
                default: ;
            endcase
        end
    end

    assign rd_region = (read && hit) ? sel_region : REGION_NONE;
    assign rd_osc    = osc_idx;

endmodule

//--- logic/osc_param_regs.sv
`timescale 1ns/10ps

module osc_param_regs
    import synth_types_pkg::*;
    import synth_map_pkg::*;
#(
    parameter int OSC_INDEX = 0
) (
    input  logic                    reg_clk,
    input  logic                    reset_reg_N,
    input  logic                    osc_wr,
    input  logic                    mat1_wr,
    input  logic                    mat2_wr,
    input  logic [SUB_ADR_W-1:0]    sub_adr,
    input  ctrl_byte_t              data_in,
    input  reg_region_t             rd_region,
    output ctrl_byte_t              lvl,
    output ctrl_byte_t              mod_out,
    output ctrl_byte_t              feedb_out,
    output ctrl_byte_t              pan,
    output ctrl_byte_t              mod_in,
    output ctrl_byte_t              feedb_in,
    output ctrl_byte_t              mat1_col [MAT_SLOTS-1:0],
    output ctrl_byte_t              mat2_col [MAT_SLOTS-1:0],
    output ctrl_byte_t              rd_data
);

    // --------------------
    // Mixer fields
    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            lvl       <= (OSC_INDEX < LVL_ON_COUNT) ? LVL_ON : '0;
            mod_out   <= '0;
            feedb_out <= '0;
            pan       <= PAN_CENTER;
            mod_in    <= '0;
            feedb_in  <= '0;
        end else if (osc_wr) begin
            case (sub_adr)
                FIELD_LVL:       lvl       <= data_in;
                FIELD_MOD_OUT:   mod_out   <= data_in;
                FIELD_FEEDB_OUT: feedb_out <= data_in;
                FIELD_PAN:       pan       <= data_in;
                FIELD_MOD_IN:    mod_in    <= data_in;
                FIELD_FEEDB_IN:  feedb_in  <= data_in;
                default: ;                              // Unmapped field
            endcase
        end
    end

    // --------------------
    // This oscillator's column of both matrix buffers
    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            for (int s = 0; s < MAT_SLOTS; s++) begin
                mat1_col[s] <= '0;
                mat2_col[s] <= '0;
            end
        end else begin
            if (mat1_wr)
                mat1_col[sub_adr] <= data_in;
            if (mat2_wr)
                mat2_col[sub_adr] <= data_in;
        end
    end

    // --------------------
    // Local read selection
    always_comb begin
        case (rd_region)
            REGION_OSC: begin
                case (sub_adr)
                    FIELD_LVL:       rd_data = lvl;
                    FIELD_MOD_OUT:   rd_data = mod_out;
                    FIELD_FEEDB_OUT: rd_data = feedb_out;
                    FIELD_PAN:       rd_data = pan;
                    FIELD_MOD_IN:    rd_data = mod_in;
                    FIELD_FEEDB_IN:  rd_data = feedb_in;
                    default:         rd_data = '0;      // Includes fields 12 to 15
                endcase
            end
            REGION_MAT1: rd_data = mat1_col[sub_adr];
            REGION_MAT2: rd_data = mat2_col[sub_adr];
            default:     rd_data = '0;
        endcase
    end

    // Decoder must hand each slice at most one enable per cycle
    a_one_enable: assert property (
        @(posedge reg_clk) disable iff (!reset_reg_N)
        $onehot0({osc_wr, mat1_wr, mat2_wr})
    ) else $error("Slice %0d got more than one write enable", OSC_INDEX);

endmodule

//--- logic/common_regs.sv
`timescale 1ns/10ps

module common_regs
    import synth_types_pkg::*;
    import synth_map_pkg::*;
(
    input  logic            reg_clk,
    input  logic            reset_reg_N,
    input  logic            com_wr,
    input  ctrl_adr_t       adr,
    input  ctrl_byte_t      data_in,
    output ctrl_byte_t      m_vol,
    output midi_ch_t        midi_ch,
    output ctrl_byte_t      patch_name [NAME_LEN-1:0],
    output ctrl_byte_t      com_rd_data
);

    ctrl_adr_t               name_off;
    logic                    name_hit;
    logic [NAME_IDX_W-1:0]   name_idx;

    // Wraps to a large value below the name base
    assign name_off = adr - ctrl_adr_t'(COM_NAME_BASE);
    assign name_hit = (name_off < NAME_LEN);
    assign name_idx = name_off[NAME_IDX_W-1:0];

    // --------------------
    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            m_vol   <= VOL_DEFAULT;
            midi_ch <= '0;
            for (int i = 0; i < NAME_LEN; i++) begin
                patch_name[i] <= NAME_FILL;
            end
        end else if (com_wr) begin
            if (adr == COM_VOL)
                m_vol <= data_in;
            else if (adr == COM_CH)
                midi_ch <= data_in[$bits(midi_ch_t)-1:0];      // Low nibble only
            else if (name_hit)
                patch_name[name_idx] <= data_in;
        end
    end

    // --------------------
    always_comb begin
        if (adr == COM_VOL)
            com_rd_data = m_vol;
        else if (adr == COM_CH)
            com_rd_data = {{($bits(ctrl_byte_t)-$bits(midi_ch_t)){1'b0}}, midi_ch};
        else if (name_hit)
            com_rd_data = patch_name[name_idx];
        else
            com_rd_data = '0;                               // 0 and 3 to 15 are unmapped
    end

endmodule

//--- logic/readback_mux.sv
`timescale 1ns/10ps

module readback_mux
    import synth_types_pkg::*;
    import synth_map_pkg::*;
(
    input  logic                    reg_clk,
    input  logic                    reset_reg_N,
    input  reg_region_t             rd_region,
    input  logic [OSC_IDX_W-1:0]    rd_osc,
    input  ctrl_byte_t              slice_rd_data [V_OSC-1:0],
    input  ctrl_byte_t              com_rd_data,
    output ctrl_byte_t              regdata_out
);

    ctrl_byte_t     slice_pick;
    logic           slice_region;

    assign slice_region = (rd_region == REGION_OSC)  ||
                          (rd_region == REGION_MAT1) ||
                          (rd_region == REGION_MAT2);

    // --------------------
    // Slice selected by oscillator index
    always_comb begin
        slice_pick = '0;
        for (int i = 0; i < V_OSC; i++) begin
            if (rd_osc == i)
                slice_pick = slice_rd_data[i];
        end
    end

    // --------------------
    // Read register, loads only on an accepted read
    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            regdata_out <= '0;
        end else begin
            case (rd_region)
                REGION_OSC,
                REGION_MAT1,
                REGION_MAT2: regdata_out <= slice_pick;
                REGION_COM:  regdata_out <= com_rd_data;
                default: ;                                  // Hold last read
            endcase
        end
    end

    // Decoder filters out-of-range oscillators before they reach here
    a_osc_in_range: assert property (
        @(posedge reg_clk) disable iff (!reset_reg_N)
        slice_region |-> (rd_osc < V_OSC)
    ) else $error("Slice read with oscillator index %0d", rd_osc);

endmodule

//--- logic/synth_ctrl_regs.sv
`timescale 1ns/10ps

module synth_ctrl_regs
    import synth_types_pkg::*;
    import synth_map_pkg::*;
(
    input  logic            reg_clk,
    input  logic            reset_reg_N,
    input  ctrl_adr_t       adr,
    input  logic            write,
    input  logic            read,
    input  logic            osc_sel,
    input  logic            com_sel,
    input  logic            m1_sel,
    input  logic            m2_sel,
    input  ctrl_byte_t      synth_data_in,
    output ctrl_byte_t      osc_lvl       [V_OSC-1:0],
    output ctrl_byte_t      osc_mod_out   [V_OSC-1:0],
    output ctrl_byte_t      osc_feedb_out [V_OSC-1:0],
    output ctrl_byte_t      osc_pan       [V_OSC-1:0],
    output ctrl_byte_t      osc_mod_in    [V_OSC-1:0],
    output ctrl_byte_t      osc_feedb_in  [V_OSC-1:0],
    output ctrl_byte_t      mat_buf1      [MAT_SLOTS-1:0][V_OSC-1:0],
    output ctrl_byte_t      mat_buf2      [MAT_SLOTS-1:0][V_OSC-1:0],
    output ctrl_byte_t      m_vol,
    output midi_ch_t        midi_ch,
    output ctrl_byte_t      patch_name    [NAME_LEN-1:0],
    output ctrl_byte_t      regdata_out
);

    logic [V_OSC-1:0]       osc_wr;
    logic [V_OSC-1:0]       mat1_wr;
    logic [V_OSC-1:0]       mat2_wr;
    logic                   com_wr;
    logic [SUB_ADR_W-1:0]   sub_adr;
    reg_region_t            rd_region;
    logic [OSC_IDX_W-1:0]   rd_osc;
    ctrl_byte_t             slice_rd_data [V_OSC-1:0];
    ctrl_byte_t             com_rd_data;

    ctrl_bus_decoder u_decoder (
        .adr       (adr),
        .write     (write),
        .read      (read),
        .osc_sel   (osc_sel),
        .com_sel   (com_sel),
        .m1_sel    (m1_sel),
        .m2_sel    (m2_sel),
        .osc_wr    (osc_wr),
        .mat1_wr   (mat1_wr),
        .mat2_wr   (mat2_wr),
        .com_wr    (com_wr),
        .sub_adr   (sub_adr),
        .rd_region (rd_region),
        .rd_osc    (rd_osc)
    );

    // --------------------
    // One slice per oscillator, columns fanned out slot-major
    for (genvar i = 0; i < V_OSC; i++) begin : g_osc
        ctrl_byte_t mat1_col [MAT_SLOTS-1:0];
        ctrl_byte_t mat2_col [MAT_SLOTS-1:0];

        osc_param_regs #(.OSC_INDEX(i)) u_osc (
            .reg_clk     (reg_clk),
            .reset_reg_N (reset_reg_N),
            .osc_wr      (osc_wr[i]),
            .mat1_wr     (mat1_wr[i]),
            .mat2_wr     (mat2_wr[i]),
            .sub_adr     (sub_adr),
            .data_in     (synth_data_in),
            .rd_region   (rd_region),
            .lvl         (osc_lvl[i]),
            .mod_out     (osc_mod_out[i]),
            .feedb_out   (osc_feedb_out[i]),
            .pan         (osc_pan[i]),
            .mod_in      (osc_mod_in[i]),
            .feedb_in    (osc_feedb_in[i]),
            .mat1_col    (mat1_col),
            .mat2_col    (mat2_col),
            .rd_data     (slice_rd_data[i])
        );

        for (genvar s = 0; s < MAT_SLOTS; s++) begin : g_slot
            assign mat_buf1[s][i] = mat1_col[s];
            assign mat_buf2[s][i] = mat2_col[s];
        end
    end

    common_regs u_common (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .com_wr      (com_wr),
        .adr         (adr),
        .data_in     (synth_data_in),
        .m_vol       (m_vol),
        .midi_ch     (midi_ch),
        .patch_name  (patch_name),
        .com_rd_data (com_rd_data)
    );

    readback_mux u_readback (
        .reg_clk       (reg_clk),
        .reset_reg_N   (reset_reg_N),
        .rd_region     (rd_region),
        .rd_osc        (rd_osc),
        .slice_rd_data (slice_rd_data),
        .com_rd_data   (com_rd_data),
        .regdata_out   (regdata_out)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic reg_clk,
    output logic reset_reg_N
);

    initial begin
        reg_clk = 1'b0;
        forever #(PERIOD_NS / 2) reg_clk = ~reg_clk;
    end

    initial begin
        reset_reg_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge reg_clk);
        #1 reset_reg_N = 1'b1;                  // Just after the last reset edge
    end

endmodule

//--- test/tb_synth_ctrl_regs.sv
`timescale 1ns/10ps

module tb_synth_ctrl_regs
    import synth_types_pkg::*;
    import synth_map_pkg::*;
();

    localparam int EDGE_TIMEOUT = 100;          // Polling steps of 1 ns

    logic       reg_clk;
    logic       reset_reg_N;
    ctrl_adr_t  adr;
    logic       write;
    logic       read;
    logic       osc_sel;
    logic       com_sel;
    logic       m1_sel;
    logic       m2_sel;
    ctrl_byte_t synth_data_in;
    ctrl_byte_t osc_lvl [V_OSC-1:0];
    ctrl_byte_t osc_mod_out [V_OSC-1:0];
    ctrl_byte_t osc_feedb_out [V_OSC-1:0];
    ctrl_byte_t osc_pan [V_OSC-1:0];
    ctrl_byte_t osc_mod_in [V_OSC-1:0];
    ctrl_byte_t osc_feedb_in [V_OSC-1:0];
    ctrl_byte_t mat_buf1 [MAT_SLOTS-1:0][V_OSC-1:0];
    ctrl_byte_t mat_buf2 [MAT_SLOTS-1:0][V_OSC-1:0];
    ctrl_byte_t m_vol;
    midi_ch_t   midi_ch;
    ctrl_byte_t patch_name [NAME_LEN-1:0];
    ctrl_byte_t regdata_out;

    // Shadow registers, oscillator then field or slot
    logic [7:0] sh_osc [V_OSC][16];
    logic [7:0] sh_m1 [V_OSC][MAT_SLOTS];
    logic [7:0] sh_m2 [V_OSC][MAT_SLOTS];
    logic [7:0] sh_com [32];                    // By common address

    int unsigned lcg_state = 83281;
    int cyc = 0;
    int n_checks = 0;
    int n_errors = 0;

    tb_clock_gen u_clk (.reg_clk(reg_clk), .reset_reg_N(reset_reg_N));

    synth_ctrl_regs UUT (.*);

    always @(posedge reg_clk) cyc <= cyc + 1;

    // --------------------
    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic bit field_mapped(logic [3:0] f);
        return (f == FIELD_LVL) || (f == FIELD_MOD_OUT) || (f == FIELD_FEEDB_OUT) ||
               (f == FIELD_PAN) || (f == FIELD_MOD_IN) || (f == FIELD_FEEDB_IN);
    endfunction

    function automatic reg_region_t pick_region(logic [3:0] sel);
        casez (sel)                             // osc, com, m1, m2
            4'b1???: return REGION_OSC;
            4'b01??: return REGION_COM;
            4'b001?: return REGION_MAT1;
            4'b0001: return REGION_MAT2;
            default: return REGION_NONE;
        endcase
    endfunction

    function automatic logic [7:0] model_read(logic [3:0] sel, ctrl_adr_t a);
        int o;
        o = a[6:4];
        case (pick_region(sel))
            REGION_OSC:  return (o < V_OSC) ? sh_osc[o][a[3:0]] : 8'h00;
            REGION_MAT1: return (o < V_OSC) ? sh_m1[o][a[3:0]] : 8'h00;
            REGION_MAT2: return (o < V_OSC) ? sh_m2[o][a[3:0]] : 8'h00;
            REGION_COM:  return (a < 32) ? sh_com[a] : 8'h00;
            default:     return 8'h00;
        endcase
    endfunction

    task automatic model_write(logic [3:0] sel, ctrl_adr_t a, logic [7:0] d);
        int o;
        o = a[6:4];
        case (pick_region(sel))
            REGION_OSC:  if (o < V_OSC && field_mapped(a[3:0])) sh_osc[o][a[3:0]] = d;
            REGION_MAT1: if (o < V_OSC) sh_m1[o][a[3:0]] = d;
            REGION_MAT2: if (o < V_OSC) sh_m2[o][a[3:0]] = d;
            REGION_COM: begin
                if (a == COM_VOL || (a >= COM_NAME_BASE && a < COM_NAME_BASE + NAME_LEN))
                    sh_com[a] = d;
                else if (a == COM_CH)
                    sh_com[a] = {4'h0, d[3:0]};
            end
            default: ;
        endcase
    endtask

    task automatic init_model();
        for (int o = 0; o < V_OSC; o++) begin
            for (int k = 0; k < MAT_SLOTS; k++) begin
                sh_osc[o][k] = 8'h00;
                sh_m1[o][k] = 8'h00;
                sh_m2[o][k] = 8'h00;
            end
            sh_osc[o][FIELD_LVL] = (o < LVL_ON_COUNT) ? LVL_ON : 8'h00;
            sh_osc[o][FIELD_PAN] = PAN_CENTER;
        end
        for (int a = 0; a < 32; a++)
            sh_com[a] = (a >= COM_NAME_BASE) ? NAME_FILL : 8'h00;
        sh_com[COM_VOL] = VOL_DEFAULT;
    endtask

    task automatic check(logic [7:0] got, logic [7:0] exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    // --------------------
    task automatic wait_edge();
        int start;
        int guard;
        start = cyc;
        guard = 0;
        while (cyc == start && guard < EDGE_TIMEOUT) begin
            #1;
            guard++;
        end
        if (cyc == start) begin
            $display("No rising edge on reg_clk within %0d ns", EDGE_TIMEOUT);
            $display("Simulation FAILED");
            $finish;
        end else begin
            #4;                                 // Back at the drive point
        end
    endtask

    task automatic bus_drive(logic [3:0] sel, ctrl_adr_t a, logic [7:0] d, logic wr, logic rd);
        {osc_sel, com_sel, m1_sel, m2_sel} = sel;
        adr = a;
        synth_data_in = d;
        write = wr;
        read = rd;
        wait_edge();
        {osc_sel, com_sel, m1_sel, m2_sel} = 4'b0000;
        write = 1'b0;
        read = 1'b0;
    endtask

    task automatic bus_write(logic [3:0] sel, ctrl_adr_t a, logic [7:0] d);
        bus_drive(sel, a, d, 1'b1, 1'b0);
        model_write(sel, a, d);
    endtask

    task automatic bus_read(logic [3:0] sel, ctrl_adr_t a, string what);
        bus_drive(sel, a, 8'h00, 1'b0, 1'b1);
        check(regdata_out, model_read(sel, a), $sformatf("%s read at %0d", what, a));
    endtask

    task automatic sweep_reads();
        for (int a = 0; a < V_OSC * 16; a++) begin
            bus_read(4'b1000, a, "osc");
            bus_read(4'b0010, a, "mat1");
            bus_read(4'b0001, a, "mat2");
        end
        for (int a = 0; a < 32; a++)
            bus_read(4'b0100, a, "com");
    endtask

    task automatic check_ports();
        for (int o = 0; o < V_OSC; o++) begin
            check(osc_lvl[o], sh_osc[o][FIELD_LVL], $sformatf("osc_lvl[%0d]", o));
            check(osc_mod_out[o], sh_osc[o][FIELD_MOD_OUT], $sformatf("osc_mod_out[%0d]", o));
            check(osc_feedb_out[o], sh_osc[o][FIELD_FEEDB_OUT],
                  $sformatf("osc_feedb_out[%0d]", o));
            check(osc_pan[o], sh_osc[o][FIELD_PAN], $sformatf("osc_pan[%0d]", o));
            check(osc_mod_in[o], sh_osc[o][FIELD_MOD_IN], $sformatf("osc_mod_in[%0d]", o));
            check(osc_feedb_in[o], sh_osc[o][FIELD_FEEDB_IN], $sformatf("osc_feedb_in[%0d]", o));
            for (int s = 0; s < MAT_SLOTS; s++) begin
                check(mat_buf1[s][o], sh_m1[o][s], $sformatf("mat_buf1[%0d][%0d]", s, o));
                check(mat_buf2[s][o], sh_m2[o][s], $sformatf("mat_buf2[%0d][%0d]", s, o));
            end
        end
        check(m_vol, sh_com[COM_VOL], "m_vol");
        check({4'h0, midi_ch}, sh_com[COM_CH], "midi_ch");
        for (int i = 0; i < NAME_LEN; i++)
            check(patch_name[i], sh_com[COM_NAME_BASE + i], $sformatf("patch_name[%0d]", i));
    endtask

    // --------------------
    task automatic verify_reset();
        init_model();
        check(regdata_out, 8'h00, "regdata_out after reset");
        check_ports();
        sweep_reads();
    endtask

    task automatic exercise_osc_fields();
        for (int a = 0; a < V_OSC * 16; a++) begin
            bus_write(4'b1000, a, lcg_byte());  // Fields 12 to 15 must not stick
            check_ports();
        end
        sweep_reads();
    endtask

    task automatic exercise_common();
        for (int a = 0; a < 32; a++)
            bus_write(4'b0100, a, lcg_byte());
        bus_write(4'b0100, COM_CH, 8'hB5);      // High nibble dropped
        check_ports();
        sweep_reads();
    endtask

    task automatic fill_matrices();
        for (int a = 0; a < 128; a++) begin     // Oscillators 4 to 7 above 63
            bus_write(4'b0010, a, lcg_byte());
            bus_write(4'b0001, a, lcg_byte());
            if (a >= V_OSC * 16)
                bus_write(4'b1000, a, lcg_byte());
        end
        check_ports();
        sweep_reads();
    endtask

    task automatic probe_bus_control();
        logic [7:0] old;
        bus_write(4'b1111, 16 + FIELD_PAN, lcg_byte());
        bus_write(4'b0111, COM_VOL, lcg_byte());
        bus_write(4'b0011, 5, lcg_byte());
        check_ports();
        bus_drive(4'b1111, FIELD_LVL, 8'h5A, 1'b0, 1'b0);
        bus_drive(4'b0100, COM_VOL, 8'h5A, 1'b0, 1'b0);
        check_ports();
        old = model_read(4'b1000, 32 + FIELD_MOD_IN);
        bus_drive(4'b1000, 32 + FIELD_MOD_IN, 8'hC3, 1'b1, 1'b1);
        check(regdata_out, old, "read in the write cycle");
        model_write(4'b1000, 32 + FIELD_MOD_IN, 8'hC3);
        check_ports();
        bus_read(4'b1000, 32 + FIELD_MOD_IN, "osc after write");
    endtask

    // --------------------
    initial begin
        int n;
        {osc_sel, com_sel, m1_sel, m2_sel} = 4'b0000;
        adr = '0;
        write = 1'b0;
        read = 1'b0;
        synth_data_in = '0;
        n = 0;
        while (!reset_reg_N && n < 10) begin
            wait_edge();
            n++;
        end
        if (!reset_reg_N) begin
            $display("Reset was never released");
            $display("Simulation FAILED");
            $finish;
        end else begin
            verify_reset();
            exercise_osc_fields();
            exercise_common();
            fill_matrices();
            probe_bus_control();
            $display("Checks: %0d, errors: %0d", n_checks, n_errors);
            if (n_errors == 0)
                $display("Simulation PASSED");
            else
                $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

//--- flist.f
logic/synth_types_pkg.sv
logic/synth_map_pkg.sv
logic/ctrl_bus_decoder.sv
logic/osc_param_regs.sv
logic/common_regs.sv
logic/readback_mux.sv
logic/synth_ctrl_regs.sv
test/tb_clock_gen.sv
test/tb_synth_ctrl_regs.sv

//--- Bender.yml
package:
  name: synth_ctrl_regs

sources:
  - logic/synth_types_pkg.sv
  - logic/synth_map_pkg.sv
  - logic/ctrl_bus_decoder.sv
  - logic/osc_param_regs.sv
  - logic/common_regs.sv
  - logic/readback_mux.sv
  - logic/synth_ctrl_regs.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_synth_ctrl_regs.sv
